/* source/wb_pkg.sv */
////////////////////////////////////////
// Write-back subsystem package
// Shared widths, data memory geometry
// and index types for the back end of
// the in-order core
////////////////////////////////////////

package wb_pkg;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Width of one machine word
  localparam int unsigned XLEN = 32;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Five index bits select one of 32 registers
  localparam int unsigned RF_ADDR_W = 5;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////

  // Word-addressed, no byte lanes
  localparam int unsigned DMEM_DEPTH = 64;

  // Must cover DMEM_DEPTH words
  localparam int unsigned DMEM_ADDR_W = 6;

  typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

endpackage

/* source/ex_wb_pipe.sv */
////////////////////////////////////////
// EX/WB pipeline register
// Holds one executed instruction and
// its valid bit until write-back frees
////////////////////////////////////////

`timescale 1ns/1ps

module ex_wb_pipe import wb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Issue side
  input  logic             issue_valid_i,
  input  logic             wb_ready_i,
  input  logic             rf_we_i,
  input  rf_addr_t         rf_waddr_i,
  input  logic [XLEN-1:0]  alu_result_i,
  input  logic             lsu_en_i,

  // Toward write-back
  output logic             valid_o,
  output logic             rf_we_o,
  output rf_addr_t         rf_waddr_o,
  output logic [XLEN-1:0]  alu_result_o,
  output logic             lsu_en_o
);

  ////////////////////////////////////////
  // Control bits
  ////////////////////////////////////////

  // Valid and the two enables are cleared by reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      rf_we_o  <= 1'b0;
      lsu_en_o <= 1'b0;
    end else if (wb_ready_i) begin
      // WB can take a new one, so the slot is refilled or emptied
      valid_o  <= issue_valid_i;
      rf_we_o  <= rf_we_i;
      lsu_en_o <= lsu_en_i;
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  // Only meaningful while valid_o is high
  always_ff @(posedge clk_i) begin
    if (wb_ready_i) begin
      rf_waddr_o   <= rf_waddr_i;
      alu_result_o <= alu_result_i;
    end
  end

  // A stalled instruction must reach WB unchanged in the next cycle
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !wb_ready_i |=>
      valid_o && $stable({rf_we_o, rf_waddr_o, alu_result_o, lsu_en_o})
  ) else $error("ex_wb_pipe: instruction changed while stalled in WB");

endmodule

/* source/load_store_unit.sv */
////////////////////////////////////////
// Load/store unit
// Word-addressed data memory with a
// synchronous access at issue and a
// one-entry response register for WB
////////////////////////////////////////

`timescale 1ns/1ps

module load_store_unit import wb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Request, taken together with the issue handshake
  input  logic             req_valid_i,
  input  logic             ex_ready_i,
  input  logic             lsu_en_i,
  input  logic             lsu_we_i,
  input  dmem_addr_t       addr_i,
  input  logic [XLEN-1:0]  wdata_i,

  // Response toward write-back
  input  logic             lsu_ready_i,
  output logic             lsu_valid_o,
  output logic [XLEN-1:0]  lsu_rdata_o
);

  ////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////

  logic            req_accept;
  logic            rsp_consume;
  logic [XLEN-1:0] mem_q [DMEM_DEPTH];

  // A load/store enters on the same edge as its instruction
  assign req_accept  = req_valid_i && ex_ready_i && lsu_en_i;

  // WB takes the response when it completes or drops the instruction
  assign rsp_consume = lsu_valid_o && lsu_ready_i;

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      if (lsu_we_i) begin
        // Store commits here, a later kill cannot take it back
        mem_q[addr_i] <= wdata_i;
      end else begin
        lsu_rdata_o <= mem_q[addr_i];
      end
    end
  end

  ////////////////////////////////////////
  // Response valid
  ////////////////////////////////////////

  // New request wins over the consume of the previous one
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lsu_valid_o <= 1'b0;
    end else if (req_accept) begin
      lsu_valid_o <= 1'b1;
    end else if (rsp_consume) begin
      lsu_valid_o <= 1'b0;
    end
  end

  // One entry only, so WB must drain it before the next request lands
  a_no_overrun : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_accept |-> !lsu_valid_o || lsu_ready_i
  ) else $error("load_store_unit: request while response still held");

endmodule

/* source/wb_stage.sv */
////////////////////////////////////////
// Write-back stage
// Picks ALU or load data, gates the
// register write and reports commit
////////////////////////////////////////

`timescale 1ns/1ps

module wb_stage import wb_pkg::*; (
  // From EX/WB pipeline register
  input  logic             valid_i,
  input  logic             rf_we_i,
  input  rf_addr_t         rf_waddr_i,
  input  logic [XLEN-1:0]  alu_result_i,
  input  logic             lsu_en_i,

  // Load/store response
  input  logic             lsu_valid_i,
  input  logic [XLEN-1:0]  lsu_rdata_i,
  output logic             lsu_ready_o,

  // Stand-in for controller FSM
  input  logic             halt_wb_i,
  input  logic             kill_wb_i,

  // Register file write port
  output logic             rf_we_o,
  output rf_addr_t         rf_waddr_o,
  output logic [XLEN-1:0]  rf_wdata_o,

  output logic             wb_valid_o,
  output logic             wb_ready_o
);

  logic instr_valid;
  logic instr_done;

  // Kill turns the held instruction into a bubble
  assign instr_valid = valid_i && !kill_wb_i;

  // Load/store waits for its response, halt freezes everything
  assign instr_done  = instr_valid && !halt_wb_i && (!lsu_en_i || lsu_valid_i);

  assign rf_we_o     = instr_done && rf_we_i;
  assign rf_waddr_o  = rf_waddr_i;
  assign rf_wdata_o  = lsu_en_i ? lsu_rdata_i : alu_result_i;

  assign wb_valid_o  = instr_done;

  // Free slot, finishing now, or being thrown away
  assign wb_ready_o  = !valid_i || instr_done || kill_wb_i;

  // Drain the response on commit, and also on kill so none is left behind
  assign lsu_ready_o = valid_i && lsu_en_i && (instr_done || kill_wb_i);

  // Response register is filled at issue, so a load/store in WB has one
  always_comb begin
    a_rsp_present : assert final (!(valid_i && lsu_en_i) || lsu_valid_i)
      else $error("wb_stage: load/store in WB without LSU response");
  end

endmodule

/* source/register_file.sv */
////////////////////////////////////////
// Register file
// 32 x 32-bit, one write and one read
// port, x0 hardwired to zero
////////////////////////////////////////

`timescale 1ns/1ps

module register_file import wb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Write port from write-back
  input  logic             we_i,
  input  rf_addr_t         waddr_i,
  input  logic [XLEN-1:0]  wdata_i,

  // Combinational read port
  input  rf_addr_t         raddr_i,
  output logic [XLEN-1:0]  rdata_o
);

  // No storage for x0
  logic [XLEN-1:0] regs_q [31:1];

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes to x0 are dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Same-edge write shows up right after the edge
  always_comb begin
    if (raddr_i == '0) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs_q[raddr_i];
    end
  end

endmodule

/* source/wb_subsystem_top.sv */
////////////////////////////////////////
// Write-back subsystem top
// EX/WB register, load/store unit,
// write-back stage and register file
////////////////////////////////////////

`timescale 1ns/1ps

module wb_subsystem_top import wb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Issue of executed instructions
  input  logic             issue_valid_i,
  output logic             issue_ready_o,
  input  logic             issue_rf_we_i,
  input  rf_addr_t         issue_rf_waddr_i,
  input  logic [XLEN-1:0]  issue_alu_result_i,
  input  logic             issue_lsu_en_i,
  input  logic             issue_lsu_we_i,
  input  dmem_addr_t       issue_lsu_addr_i,
  input  logic [XLEN-1:0]  issue_lsu_wdata_i,

  // WB controls
  input  logic             halt_wb_i,
  input  logic             kill_wb_i,

  // Commit port
  output logic             wb_valid_o,
  output logic             rf_we_o,
  output rf_addr_t         rf_waddr_o,
  output logic [XLEN-1:0]  rf_wdata_o,

  // Register read-back
  input  rf_addr_t         rf_raddr_i,
  output logic [XLEN-1:0]  rf_rdata_o
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  logic             wb_ready;
  logic             pipe_valid;
  logic             pipe_rf_we;
  rf_addr_t         pipe_rf_waddr;
  logic [XLEN-1:0]  pipe_alu_result;
  logic             pipe_lsu_en;
  logic             lsu_valid;
  logic             lsu_ready;
  logic [XLEN-1:0]  lsu_rdata;

  // Issue handshake is just the WB ready
  assign issue_ready_o = wb_ready;

  ex_wb_pipe ex_wb_pipe_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .wb_ready_i    (wb_ready),
    .rf_we_i       (issue_rf_we_i),
    .rf_waddr_i    (issue_rf_waddr_i),
    .alu_result_i  (issue_alu_result_i),
    .lsu_en_i      (issue_lsu_en_i),
    .valid_o       (pipe_valid),
    .rf_we_o       (pipe_rf_we),
    .rf_waddr_o    (pipe_rf_waddr),
    .alu_result_o  (pipe_alu_result),
    .lsu_en_o      (pipe_lsu_en)
  );

  load_store_unit load_store_unit_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (issue_valid_i),
    .ex_ready_i  (wb_ready),
    .lsu_en_i    (issue_lsu_en_i),
    .lsu_we_i    (issue_lsu_we_i),
    .addr_i      (issue_lsu_addr_i),
    .wdata_i     (issue_lsu_wdata_i),
    .lsu_ready_i (lsu_ready),
    .lsu_valid_o (lsu_valid),
    .lsu_rdata_o (lsu_rdata)
  );

  wb_stage wb_stage_i (
    .valid_i      (pipe_valid),
    .rf_we_i      (pipe_rf_we),
    .rf_waddr_i   (pipe_rf_waddr),
    .alu_result_i (pipe_alu_result),
    .lsu_en_i     (pipe_lsu_en),
    .lsu_valid_i  (lsu_valid),
    .lsu_rdata_i  (lsu_rdata),
    .lsu_ready_o  (lsu_ready),
    .halt_wb_i    (halt_wb_i),
    .kill_wb_i    (kill_wb_i),
    .rf_we_o      (rf_we_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_wdata_o   (rf_wdata_o),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_o   (wb_ready)
  );

  register_file register_file_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .we_i    (rf_we_o),
    .waddr_i (rf_waddr_o),
    .wdata_i (rf_wdata_o),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

/* sim/wb_checker.sv */
////////////////////////////////////////
// Commit checker
// Compares commits and register reads
// with the expected commit stream
////////////////////////////////////////

`timescale 1ns/1ps

module wb_checker import wb_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             issue_ready_i,
  input  logic             halt_wb_i,
  input  logic             kill_wb_i,
  input  logic             wb_valid_i,
  input  logic             rf_we_i,
  input  rf_addr_t         rf_waddr_i,
  input  logic [XLEN-1:0]  rf_wdata_i,
  input  rf_addr_t         rf_raddr_i,
  input  logic [XLEN-1:0]  rf_rdata_i,
  input  logic             readback_i
);

  // Expected {rf_we, rd, data}, head is the instruction in WB
  logic [XLEN+RF_ADDR_W:0] exp_q [$];
  logic [XLEN-1:0]         model_rf [32];
  string                   test_name = "";
  int                      tests = 0;
  int                      checks = 0;
  int                      errors = 0;
  int                      commits;
  int                      killed;
  int                      errors_at_start;
  logic                    occupied;
  logic                    exp_commit;
  logic                    head_we;
  rf_addr_t                head_rd;
  logic [XLEN-1:0]         head_data;

  initial begin
    foreach (model_rf[i]) begin
      model_rf[i] = '0;
    end
  end

  task push_expected(input logic [XLEN+RF_ADDR_W:0] c);
    exp_q.push_back(c);
  endtask

  function int pending();
    return exp_q.size();
  endfunction

  task begin_test(input string name);
    test_name       = name;
    commits         = 0;
    killed          = 0;
    errors_at_start = errors;
  endtask

  task end_test();
    tests++;
    $display("test %s: %0d commits, %0d killed, %0d errors",
             test_name, commits, killed, errors - errors_at_start);
  endtask

  task check_value(input string what, input logic [XLEN-1:0] exp_v,
                   input logic [XLEN-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("error %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle compare
  ////////////////////////////////////////

  // Falling edge, inputs settled since the rising edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      occupied = exp_q.size() != 0;
      {head_we, head_rd, head_data} = occupied ? exp_q[0] : '0;
      // Kill beats halt, halt blocks the commit
      exp_commit = occupied && !kill_wb_i && !halt_wb_i;
      check_value("issue_ready", XLEN'(!(occupied && halt_wb_i && !kill_wb_i)),
                  XLEN'(issue_ready_i));
      check_value("wb_valid", XLEN'(exp_commit), XLEN'(wb_valid_i));
      check_value("rf_we", XLEN'(exp_commit && head_we), XLEN'(rf_we_i));
      if (exp_commit && head_we) begin
        check_value("rf_waddr", XLEN'(head_rd), XLEN'(rf_waddr_i));
        check_value("rf_wdata", head_data, rf_wdata_i);
        // x0 keeps zero
        if (head_rd != '0) begin
          model_rf[head_rd] = head_data;
        end
      end
      if (occupied && kill_wb_i) begin
        exp_q.delete(0);
        killed++;
      end else if (exp_commit) begin
        exp_q.delete(0);
        commits++;
      end
      if (readback_i) begin
        check_value($sformatf("x%0d", rf_raddr_i), model_rf[rf_raddr_i], rf_rdata_i);
      end
    end
  end

endmodule

/* sim/tb_wb_subsystem.sv */
////////////////////////////////////////
// Write-back subsystem testbench
// Issues directed and random streams
// and predicts every commit from a model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_wb_subsystem import wb_pkg::*; ();

  typedef struct packed {
    logic            rf_we;
    rf_addr_t        rd;
    logic [XLEN-1:0] alu;
    logic            lsu_en;
    logic            lsu_we;
    dmem_addr_t      addr;
    logic [XLEN-1:0] wdata;
  } instr_t;

  localparam int unsigned N_RANDOM    = 300;
  // Directed tests add 56 instructions to the random mix
  localparam int unsigned N_TOTAL     = N_RANDOM + 56;
  localparam int unsigned CYCLE_LIMIT = 4 * N_TOTAL + 200;

  logic            clk;
  logic            rst_n;
  logic            issue_valid;
  logic            issue_ready;
  instr_t          drv;
  logic            halt_wb;
  logic            kill_wb;
  logic            wb_valid;
  logic            rf_we;
  rf_addr_t        rf_waddr;
  logic [XLEN-1:0] rf_wdata;
  rf_addr_t        rf_raddr;
  logic [XLEN-1:0] rf_rdata;
  logic            readback;

  // Model memory, written by stores at acceptance
  logic [XLEN-1:0] model_mem [DMEM_DEPTH];
  int              seed = 36;
  int              halt_pct;
  int              kill_pct;
  int              cycles = 0;
  int              op;
  // Acceptance seen at a falling edge, predicted on the next rising edge
  logic            push_pend;
  instr_t          push_ins;

  wb_subsystem_top dut_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .issue_valid_i (issue_valid), .issue_ready_o (issue_ready),
    .issue_rf_we_i (drv.rf_we), .issue_rf_waddr_i (drv.rd),
    .issue_alu_result_i (drv.alu), .issue_lsu_en_i (drv.lsu_en),
    .issue_lsu_we_i (drv.lsu_we), .issue_lsu_addr_i (drv.addr),
    .issue_lsu_wdata_i (drv.wdata), .halt_wb_i (halt_wb), .kill_wb_i (kill_wb),
    .wb_valid_o (wb_valid), .rf_we_o (rf_we), .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata), .rf_raddr_i (rf_raddr), .rf_rdata_o (rf_rdata)
  );

  wb_checker chk_i (
    .clk_i (clk), .rst_n_i (rst_n), .issue_ready_i (issue_ready),
    .halt_wb_i (halt_wb), .kill_wb_i (kill_wb), .wb_valid_i (wb_valid),
    .rf_we_i (rf_we), .rf_waddr_i (rf_waddr), .rf_wdata_i (rf_wdata),
    .rf_raddr_i (rf_raddr), .rf_rdata_i (rf_rdata), .readback_i (readback)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////

  // Expected {rf_we, rd, data}; loads see memory as it is at acceptance
  function automatic logic [XLEN+RF_ADDR_W:0] predict_commit(input instr_t ins);
    if (ins.lsu_en && ins.lsu_we) begin
      model_mem[ins.addr] = ins.wdata;
    end
    return {ins.rf_we, ins.rd, ins.lsu_en ? model_mem[ins.addr] : ins.alu};
  endfunction

  function automatic instr_t alu_op(input rf_addr_t rd, input logic [XLEN-1:0] val);
    return {1'b1, rd, val, 2'b00, {DMEM_ADDR_W{1'b0}}, {XLEN{1'b0}}};
  endfunction

  function automatic instr_t load_op(input rf_addr_t rd, input dmem_addr_t addr);
    return {1'b1, rd, {XLEN{1'b0}}, 2'b10, addr, {XLEN{1'b0}}};
  endfunction

  // No register write, so the stale response data never lands
  function automatic instr_t store_op(input dmem_addr_t addr, input logic [XLEN-1:0] val);
    return {1'b0, {RF_ADDR_W{1'b0}}, {XLEN{1'b0}}, 2'b11, addr, val};
  endfunction

  // One clock of stimulus, acc tells that the DUT takes this instruction
  task automatic tick(input logic vld, input instr_t ins, output logic acc);
    @(posedge clk);
    if (push_pend) begin
      chk_i.push_expected(predict_commit(push_ins));
      push_pend = 1'b0;
    end
    issue_valid <= vld;
    drv         <= ins;
    halt_wb     <= ($unsigned($random(seed)) % 100) < halt_pct;
    kill_wb     <= ($unsigned($random(seed)) % 100) < kill_pct;
    @(negedge clk);
    acc = vld && issue_ready;
    if (acc) begin
      push_pend = 1'b1;
      push_ins  = ins;
    end
  endtask

  task automatic send(input instr_t ins);
    logic acc;
    acc = 1'b0;
    while (!acc) begin
      tick(1'b1, ins, acc);
    end
  endtask

  // Bubbles until WB is empty, halt and kill keep their current rates
  task automatic drain();
    logic acc;
    do begin
      tick(1'b0, '0, acc);
    end while (push_pend || chk_i.pending() != 0);
  endtask

  task automatic finish_test();
    drain();
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      rf_raddr <= rf_addr_t'(r);
      readback <= 1'b1;
    end
    @(posedge clk);
    readback <= 1'b0;
    chk_i.end_test();
  endtask

  initial begin
    rst_n       <= 1'b0;
    issue_valid <= 1'b0;
    drv         <= '0;
    halt_wb     <= 1'b0;
    kill_wb     <= 1'b0;
    rf_raddr    <= '0;
    readback    <= 1'b0;
    push_pend    = 1'b0;
    halt_pct     = 0;
    kill_pct     = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    chk_i.begin_test("alu_writeback");
    for (int i = 1; i <= 8; i++) begin
      send(alu_op(rf_addr_t'(i), 32'h1000_0000 + i * 32'h0101_0101));
    end
    finish_test();

    // All 16 words written here, later loads stay inside them
    chk_i.begin_test("store_load");
    for (int i = 0; i < 16; i++) begin
      send(store_op(dmem_addr_t'(i), 32'hCAFE_0000 | (i * 32'h0000_0111)));
    end
    for (int i = 0; i < 16; i++) begin
      send(load_op(rf_addr_t'(16 + i), dmem_addr_t'(15 - i)));
    end
    finish_test();

    chk_i.begin_test("halt");
    halt_pct = 60;
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) begin
        send(alu_op(rf_addr_t'(24 + i), 32'h3300_0000 + i));
      end else begin
        send(load_op(rf_addr_t'(24 + i), dmem_addr_t'(i)));
      end
    end
    halt_pct = 0;
    finish_test();

    // Everything killed, then x7 must see the killed store
    chk_i.begin_test("kill");
    kill_pct = 100;
    send(store_op(dmem_addr_t'(3), 32'hDEAD_BEEF));
    send(alu_op(rf_addr_t'(5), 32'h5555_5555));
    send(load_op(rf_addr_t'(6), dmem_addr_t'(0)));
    drain();
    kill_pct = 0;
    send(load_op(rf_addr_t'(7), dmem_addr_t'(3)));
    send(alu_op(rf_addr_t'(8), 32'h0808_0808));
    finish_test();

    chk_i.begin_test("reg_zero");
    send(alu_op(rf_addr_t'(0), 32'hFFFF_FFFF));
    send(load_op(rf_addr_t'(0), dmem_addr_t'(1)));
    send(alu_op(rf_addr_t'(9), 32'h0000_0009));
    finish_test();

    chk_i.begin_test("random_mix");
    halt_pct = 15;
    kill_pct = 10;
    for (int i = 0; i < N_RANDOM; i++) begin
      op = $unsigned($random(seed)) % 10;
      if (op < 5) begin
        send(alu_op(rf_addr_t'($random(seed)), $random(seed)));
      end else if (op < 8) begin
        send(load_op(rf_addr_t'($random(seed)), dmem_addr_t'($unsigned($random(seed)) % 16)));
      end else begin
        send(store_op(dmem_addr_t'($unsigned($random(seed)) % 16), $random(seed)));
      end
    end
    halt_pct = 0;
    kill_pct = 0;
    finish_test();

    $display("tests: %0d, checks: %0d, errors: %0d", chk_i.tests, chk_i.checks, chk_i.errors);
    if (chk_i.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

/* files.f */
source/wb_pkg.sv
source/ex_wb_pipe.sv
source/load_store_unit.sv
source/wb_stage.sv
source/register_file.sv
source/wb_subsystem_top.sv
sim/wb_checker.sv
sim/tb_wb_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the write-back subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_wb_subsystem -f files.f -o sim_wb

./obj_dir/sim_wb | tee sim.log

# The log decides the result
if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
